// ==== rtl/dcachePkg.sv ====
`default_nettype none

package dcachePkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int wordW = 32;
    localparam int wordsPerLine = 8;
    // Byte offset within a 32-byte line
    localparam int offsetW = 5;

    typedef logic [wordW-1:0] wordT;
    typedef logic [31:0] addrT;
    typedef logic [wordsPerLine*wordW-1:0] lineT;
    // Word offset from address bits 4:2
    typedef logic [2:0] wordSelT;

    ////////////////////////////////////////////////////////////
    // Transfer structs
    ////////////////////////////////////////////////////////////

    // Processor access of 65 bits
    typedef struct packed {
        logic rw;
        addrT address;
        wordT wData;
    } cpuReqT;

    // Whole line plus its aligned address in 288 bits
    typedef struct packed {
        addrT addr;
        lineT line;
    } lineXferT;

    // Miss sequencer states
    typedef enum logic [1:0] {
        idle      = 2'd0,
        writeBack = 2'd1,
        fill      = 2'd2,
        install   = 2'd3
    } ctrlStateT;

endpackage

`default_nettype wire

// ==== rtl/storeBuffer.sv ====
`default_nettype none

module storeBuffer (
    input  wire logic              Clk,
    input  wire logic              arstN,
    input  wire logic              load,
    input  wire dcachePkg::cpuReqT req,
    input  wire logic              drain,
    output logic                   pending,
    output dcachePkg::cpuReqT      held,
    output logic                   fwdHit
);

    // Pending flag
    // A new store may arrive in the drain cycle
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pending <= 1'b0;
        end else begin
            pending <= load | (pending & ~drain);
        end
    end

    // Held store word and address
    always_ff @(posedge Clk) begin
        if (load) begin
            held <= req;
        end
    end

    // Word-address match against the buffered store
    assign fwdHit = pending && (req.address[31:2] == held.address[31:2]);

    // No overwrite of a store that has not reached the array
    noLostStore : assert property (@(posedge Clk) disable iff (!arstN)
        !(load && pending && !drain));

endmodule

`default_nettype wire

// ==== rtl/lineMerge.sv ====
`default_nettype none

module lineMerge (
    input  wire dcachePkg::lineT    line,
    input  wire dcachePkg::wordT    word,
    input  wire dcachePkg::wordSelT sel,
    output dcachePkg::lineT         merged
);

    localparam int wordW = dcachePkg::wordW;

    // One mux per word slot
    for (genvar i = 0; i < dcachePkg::wordsPerLine; i++) begin : g_word
        // Selected slot takes the store word, the rest pass through
        assign merged[i*wordW +: wordW] =
            (sel == dcachePkg::wordSelT'(i)) ? word : line[i*wordW +: wordW];
    end

endmodule

`default_nettype wire

// ==== rtl/cacheArray.sv ====
`default_nettype none

module cacheArray #(
    parameter int numSets = 16
) (
    input  wire logic                Clk,
    input  wire logic                arstN,
    // Lookup port
    input  wire dcachePkg::addrT     lookupAddr,
    output logic                     hit,
    output logic                     victimDirty,
    output dcachePkg::lineXferT      victimOut,
    output dcachePkg::wordT          rWord,
    // Word write from the store buffer
    input  wire logic                wordWe,
    input  wire dcachePkg::cpuReqT   wordReq,
    // Line install from the fill path
    input  wire logic                lineWe,
    input  wire dcachePkg::lineXferT lineIn,
    input  wire logic                lineDirty
);

    localparam int offsetW = dcachePkg::offsetW;
    localparam int indexW = $clog2(numSets);
    localparam int tagW = 32 - offsetW - indexW;

    typedef logic [indexW-1:0] indexT;
    typedef logic [tagW-1:0] tagT;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    tagT             tags [numSets];
    dcachePkg::lineT lines [numSets];
    logic [numSets-1:0] valid;
    logic [numSets-1:0] dirty;

    // Address fields of the three ports
    indexT              lkIdx;
    tagT                lkTag;
    dcachePkg::wordSelT lkSel;
    indexT              wIdx;
    dcachePkg::wordSelT wSel;
    indexT              iIdx;
    tagT                iTag;

    assign lkIdx = lookupAddr[offsetW +: indexW];
    assign lkTag = lookupAddr[31 -: tagW];
    assign lkSel = lookupAddr[4:2];
    assign wIdx = wordReq.address[offsetW +: indexW];
    assign wSel = wordReq.address[4:2];
    assign iIdx = lineIn.addr[offsetW +: indexW];
    assign iTag = lineIn.addr[31 -: tagW];

    ////////////////////////////////////////////////////////////
    // Asynchronous lookup
    ////////////////////////////////////////////////////////////

    assign hit = valid[lkIdx] && (tags[lkIdx] == lkTag);
    // Victim needs write-back only if valid and modified
    assign victimDirty = valid[lkIdx] && dirty[lkIdx];
    // Victim address rebuilt from the stored tag
    assign victimOut = '{addr: {tags[lkIdx], lkIdx, {offsetW{1'b0}}}, line: lines[lkIdx]};
    assign rWord = lines[lkIdx][{lkSel, 5'd0} +: dcachePkg::wordW];

    ////////////////////////////////////////////////////////////
    // Updates
    ////////////////////////////////////////////////////////////

    // Valid and dirty bits
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            valid <= '0;
            dirty <= '0;
        end else if (lineWe) begin
            valid[iIdx] <= 1'b1;
            // Dirty when a store word was merged in
            dirty[iIdx] <= lineDirty;
        end else if (wordWe) begin
            dirty[wIdx] <= 1'b1;
        end
    end

    // Tags and line data
    always_ff @(posedge Clk) begin
        if (lineWe) begin
            lines[iIdx] <= lineIn.line;
            tags[iIdx] <= iTag;
        end else if (wordWe) begin
            lines[wIdx][{wSel, 5'd0} +: dcachePkg::wordW] <= wordReq.wData;
        end
    end

    // Drain and install never share the write port
    onePortWrite : assert property (@(posedge Clk) disable iff (!arstN)
        !(wordWe && lineWe));

endmodule

`default_nettype wire

// ==== rtl/missControl.sv ====
`default_nettype none

module missControl (
    input  wire logic Clk,
    input  wire logic arstN,
    // Processor and lookup status
    input  wire logic en,
    input  wire logic rw,
    input  wire logic hit,
    input  wire logic victimDirty,
    input  wire logic pending,
    // Memory answers
    input  wire logic fillDone,
    input  wire logic wbDone,
    // Outputs
    output logic      stall,
    output logic      wbReq,
    output logic      fillReq,
    output logic      lineWe,
    output logic      mergeSel,
    output logic      drain,
    output logic      bufLoad
);

    dcachePkg::ctrlStateT state;
    dcachePkg::ctrlStateT nextState;

    logic isIdle;
    logic startMiss;

    assign isIdle = (state == dcachePkg::idle);

    // Miss starts only with the store buffer empty
    // A pending store may still dirty the victim set
    assign startMiss = isIdle && en && !hit && !pending;

    ////////////////////////////////////////////////////////////
    // State register and next state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= dcachePkg::idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            dcachePkg::idle: begin
                // Dirty victim goes out before the fill
                if (startMiss) begin
                    nextState = victimDirty ? dcachePkg::writeBack : dcachePkg::fill;
                end
            end
            dcachePkg::writeBack: begin
                if (wbDone) begin
                    nextState = dcachePkg::fill;
                end
            end
            dcachePkg::fill: begin
                // Line is written on the done pulse
                if (fillDone) begin
                    nextState = dcachePkg::install;
                end
            end
            dcachePkg::install: begin
                // Lookup of the held request now hits
                nextState = dcachePkg::idle;
            end
            default: begin
                nextState = dcachePkg::idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    // Combinational stall on a miss and held through the sequence
    assign stall = !isIdle || (en && !hit);

    assign wbReq = (state == dcachePkg::writeBack);
    assign fillReq = (state == dcachePkg::fill);

    // Install on the fill pulse while the data is present
    assign lineWe = fillReq && fillDone;

    // Only a miss store can be pending during the fill
    assign mergeSel = fillReq && pending;

    // Drain in idle only and never against an install
    assign drain = pending && isIdle;

    // Completing store hit, or a store miss to be merged
    assign bufLoad = en && rw && isIdle && (hit || !pending);

    // Memory requests are exclusive
    oneRequest : assert property (@(posedge Clk) disable iff (!arstN)
        !(wbReq && fillReq));

endmodule

`default_nettype wire

// ==== rtl/dataCache.sv ====
`default_nettype none

module dataCache #(
    parameter int numSets = 16
) (
    input  wire logic                Clk,
    input  wire logic                arstN,
    // Processor side
    input  wire logic                en,
    input  wire dcachePkg::cpuReqT   req,
    output dcachePkg::wordT          rData,
    output logic                     stall,
    // Write-back port
    output logic                     wbReq,
    output dcachePkg::lineXferT      wbOut,
    input  wire logic                wbDone,
    // Fill port
    output logic                     fillReq,
    output dcachePkg::addrT          fillAddr,
    input  wire logic                fillDone,
    input  wire dcachePkg::lineXferT fillIn
);

    // Store buffer status
    logic              pending;
    logic              fwdHit;
    logic              drain;
    logic              bufLoad;
    dcachePkg::cpuReqT held;

    // Array status
    logic            hit;
    logic            victimDirty;
    dcachePkg::wordT rWord;

    // Install path
    logic                lineWe;
    logic                mergeSel;
    dcachePkg::lineT     mergedLine;
    dcachePkg::lineXferT installXfer;

    ////////////////////////////////////////////////////////////
    // Write path from request to buffer to array
    ////////////////////////////////////////////////////////////

    storeBuffer u_storeBuffer (
        .Clk     (Clk),
        .arstN   (arstN),
        .load    (bufLoad),
        .req     (req),
        .drain   (drain),
        .pending (pending),
        .held    (held),
        .fwdHit  (fwdHit)
    );

    // Buffered store word into the fetched line
    lineMerge u_lineMerge (
        .line   (fillIn.line),
        .word   (held.wData),
        .sel    (held.address[4:2]),
        .merged (mergedLine)
    );

    // Merged line on a write miss, raw fill line otherwise
    assign installXfer = '{addr: fillIn.addr, line: mergeSel ? mergedLine : fillIn.line};

    cacheArray #(
        .numSets (numSets)
    ) u_cacheArray (
        .Clk         (Clk),
        .arstN       (arstN),
        .lookupAddr  (req.address),
        .hit         (hit),
        .victimDirty (victimDirty),
        .victimOut   (wbOut),
        .rWord       (rWord),
        .wordWe      (drain),
        .wordReq     (held),
        .lineWe      (lineWe),
        .lineIn      (installXfer),
        .lineDirty   (mergeSel)
    );

    ////////////////////////////////////////////////////////////
    // Miss sequencer
    ////////////////////////////////////////////////////////////

    missControl u_missControl (
        .Clk         (Clk),
        .arstN       (arstN),
        .en          (en),
        .rw          (req.rw),
        .hit         (hit),
        .victimDirty (victimDirty),
        .pending     (pending),
        .fillDone    (fillDone),
        .wbDone      (wbDone),
        .stall       (stall),
        .wbReq       (wbReq),
        .fillReq     (fillReq),
        .lineWe      (lineWe),
        .mergeSel    (mergeSel),
        .drain       (drain),
        .bufLoad     (bufLoad)
    );

    // Forwarded word wins over the array copy
    assign rData = fwdHit ? held.wData : rWord;

    // Line-aligned fill address
    assign fillAddr = {req.address[31:dcachePkg::offsetW], {dcachePkg::offsetW{1'b0}}};

endmodule

`default_nettype wire

// ==== bench/memModel.sv ====
`default_nettype none

module memModel #(
    parameter int latency = 4,
    parameter int memWords = 1024,
    parameter dcachePkg::wordT patKey = '0
) (
    input  wire logic                Clk,
    // Write-back side
    input  wire logic                wbReq,
    input  wire dcachePkg::lineXferT wbIn,
    output logic                     wbDone,
    // Fill side
    input  wire logic                fillReq,
    input  wire dcachePkg::addrT     fillAddr,
    output logic                     fillDone,
    output dcachePkg::lineXferT      fillOut
);

    // Backing store keyed by byte address
    dcachePkg::wordT mem [dcachePkg::addrT];
    int wbCnt;
    int fillCnt;

    initial begin
        // Each word holds its own byte address XOR the key
        for (int i = 0; i < memWords; i++) begin
            mem[dcachePkg::addrT'(i * 4)] = dcachePkg::addrT'(i * 4) ^ patKey;
        end
        wbDone = 1'b0;
        fillDone = 1'b0;
        fillOut = '0;
        wbCnt = 0;
        fillCnt = 0;
    end

    // Answers change 1 unit after the rising edge
    always begin
        @(posedge Clk);
        #1;
        wbDone = 1'b0;
        fillDone = 1'b0;
        // Count cycles of a held request level
        wbCnt = wbReq ? wbCnt + 1 : 0;
        fillCnt = fillReq ? fillCnt + 1 : 0;
        if (wbCnt == latency) begin
            for (int i = 0; i < 8; i++) begin
                mem[wbIn.addr + dcachePkg::addrT'(i * 4)] = wbIn.line[i*32 +: 32];
            end
            wbDone = 1'b1;
            wbCnt = 0;
        end
        if (fillCnt == latency) begin
            // Whole line in one beat
            fillOut.addr = fillAddr;
            for (int i = 0; i < 8; i++) begin
                fillOut.line[i*32 +: 32] = mem[fillAddr + dcachePkg::addrT'(i * 4)];
            end
            fillDone = 1'b1;
            fillCnt = 0;
        end
    end

endmodule

`default_nettype wire

// ==== bench/dataCacheTb.sv ====
`default_nettype none

module dataCacheTb;

    localparam int numSets = 16;
    localparam int waitLimit = 100;
    localparam dcachePkg::wordT patKey = 32'h5c3a_91e7;

    logic                Clk = 1'b0;
    logic                arstN;
    logic                en;
    dcachePkg::cpuReqT   req;
    dcachePkg::wordT     rData;
    logic                stall;
    logic                wbReq;
    dcachePkg::lineXferT wbOut;
    logic                wbDone;
    logic                fillReq;
    dcachePkg::addrT     fillAddr;
    logic                fillDone;
    dcachePkg::lineXferT fillIn;

    // What each word should read
    dcachePkg::wordT refMem [dcachePkg::addrT];

    int              errors = 0;
    int              loads = 0;
    integer          seed = 32'h763b_74c5;
    logic            sawWb;
    logic            sawFill;
    dcachePkg::addrT lastWbAddr;

    dataCache #(
        .numSets (numSets)
    ) u_dataCache (
        .Clk      (Clk),
        .arstN    (arstN),
        .en       (en),
        .req      (req),
        .rData    (rData),
        .stall    (stall),
        .wbReq    (wbReq),
        .wbOut    (wbOut),
        .wbDone   (wbDone),
        .fillReq  (fillReq),
        .fillAddr (fillAddr),
        .fillDone (fillDone),
        .fillIn   (fillIn)
    );

    memModel #(
        .latency  (4),
        .memWords (1024),
        .patKey   (patKey)
    ) u_memModel (
        .Clk      (Clk),
        .wbReq    (wbReq),
        .wbIn     (wbOut),
        .wbDone   (wbDone),
        .fillReq  (fillReq),
        .fillAddr (fillAddr),
        .fillDone (fillDone),
        .fillOut  (fillIn)
    );

    always #5 Clk = ~Clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic dcachePkg::wordT patternWord(input dcachePkg::addrT a);
        return a ^ patKey;
    endfunction

    function automatic dcachePkg::wordT expectedWord(input dcachePkg::addrT a);
        return refMem.exists(a) ? refMem[a] : patternWord(a);
    endfunction

    task automatic reportWrongValue(input string what, input logic [31:0] got,
                                    input logic [31:0] exp);
        errors++;
        $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    endtask

    // Line leaving the cache must match the reference
    task automatic noteWriteBack();
        dcachePkg::addrT a;
        dcachePkg::wordT w;
        sawWb = 1'b1;
        lastWbAddr = wbOut.addr;
        for (int i = 0; i < 8; i++) begin
            a = wbOut.addr + dcachePkg::addrT'(i * 4);
            w = wbOut.line[i*32 +: 32];
            if (w !== expectedWord(a)) begin
                reportWrongValue("write-back word", w, expectedWord(a));
            end
        end
    endtask

    // Fill must ask for the line that holds the access
    task automatic checkFill(input dcachePkg::addrT addr);
        dcachePkg::addrT lineAddr;
        sawFill = 1'b1;
        lineAddr = addr & 32'hffff_ffe0;
        if (fillAddr !== lineAddr) begin
            reportWrongValue("fill address", fillAddr, lineAddr);
        end
    endtask

    task automatic closeRun();
        $display("%0d loads checked, %0d errors", loads, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Processor-side access
    ////////////////////////////////////////////////////////////

    // Entered and left 1 unit after an edge
    task automatic access(input logic rw, input dcachePkg::addrT addr,
                          input dcachePkg::wordT data, output dcachePkg::wordT rd,
                          output int waits);
        waits = 0;
        sawWb = 1'b0;
        sawFill = 1'b0;
        en = 1'b1;
        req.rw = rw;
        req.address = addr;
        req.wData = data;
        // Outputs settle well before the falling edge
        @(negedge Clk);
        while (stall && waits < waitLimit) begin
            if (wbReq && wbDone) begin
                noteWriteBack();
            end
            if (fillReq && fillDone) begin
                checkFill(addr);
            end
            waits++;
            @(negedge Clk);
        end
        if (stall) begin
            errors++;
            $display("access to %h still stalled after %0d cycles, controller in %s",
                     addr, waitLimit, u_dataCache.u_missControl.state.name());
            closeRun();
        end else begin
            rd = rData;
            @(posedge Clk);
            #1;
            en = 1'b0;
        end
    endtask

    task automatic loadCheck(input dcachePkg::addrT addr, output int waits);
        dcachePkg::wordT rd;
        access(1'b0, addr, 32'h0, rd, waits);
        loads++;
        if (rd !== expectedWord(addr)) begin
            reportWrongValue("load data", rd, expectedWord(addr));
        end
    endtask

    task automatic storeWord(input dcachePkg::addrT addr, input dcachePkg::wordT data,
                             output int waits);
        dcachePkg::wordT rd;
        access(1'b1, addr, data, rd, waits);
        refMem[addr] = data;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic firstMiss();
        int waits;
        if (stall || wbReq || fillReq) begin
            errors++;
            $display("stall or a memory request is high right after reset");
        end
        loadCheck(32'h100, waits);
        // Cold set so the load has to wait for a fill
        if (waits == 0 || !sawFill) begin
            errors++;
            $display("first load at 100 did not stall for a fill");
        end
    endtask

    task automatic sameLineHit();
        int waits;
        loadCheck(32'h11c, waits);
        if (waits != 0) begin
            errors++;
            $display("load at 11c in a filled line stalled");
        end
    endtask

    task automatic storeForward();
        int waits;
        storeWord(32'h104, 32'h1234_abcd, waits);
        if (waits != 0) begin
            errors++;
            $display("store hit at 104 stalled");
        end
        // Back to back while the word still sits in the store buffer
        loadCheck(32'h104, waits);
        if (waits != 0) begin
            errors++;
            $display("forwarded load at 104 stalled");
        end
        repeat (6) @(posedge Clk);
        #1;
        // Drained into the array by now
        loadCheck(32'h104, waits);
    endtask

    task automatic storeMiss();
        int waits;
        storeWord(32'h208, 32'h7e51_c0a4, waits);
        if (waits == 0) begin
            errors++;
            $display("store to uncached line 200 did not stall");
        end
        loadCheck(32'h208, waits);
        // Neighbours come from the fill
        loadCheck(32'h200, waits);
        loadCheck(32'h21c, waits);
    endtask

    task automatic dirtyEvict();
        int waits;
        // Same set as the dirty line at 100
        loadCheck(32'h300, waits);
        if (!sawWb) begin
            errors++;
            $display("load at 300 did not write back the dirty line at 100");
        end else if (lastWbAddr !== 32'h100) begin
            reportWrongValue("write-back address", lastWbAddr, 32'h100);
        end
        // Refetch with the stored word now from memory
        loadCheck(32'h104, waits);
    endtask

    task automatic randomMix();
        dcachePkg::addrT addr;
        dcachePkg::wordT data;
        int waits;
        for (int i = 0; i < 15; i++) begin
            // Two cache sizes of address space so that sets collide
            addr = $random(seed) & 32'h0000_03fc;
            data = $random(seed);
            if ($random(seed) & 1) begin
                storeWord(addr, data, waits);
            end else begin
                loadCheck(addr, waits);
            end
        end
    endtask

    initial begin
        arstN = 1'b0;
        en = 1'b0;
        req = '0;
        sawWb = 1'b0;
        sawFill = 1'b0;
        lastWbAddr = '0;
        repeat (8) @(posedge Clk);
        #1;
        arstN = 1'b1;
        firstMiss();
        sameLineHit();
        storeForward();
        storeMiss();
        dirtyEvict();
        randomMix();
        closeRun();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/dcachePkg.sv
rtl/storeBuffer.sv
rtl/lineMerge.sv
rtl/cacheArray.sv
rtl/missControl.sv
rtl/dataCache.sv
bench/memModel.sv
bench/dataCacheTb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: obj_dir/VdataCacheTb

# Rebuilt only when a source or the file list changes
obj_dir/VdataCacheTb: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module dataCacheTb

run: obj_dir/VdataCacheTb
	./obj_dir/VdataCacheTb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "FAIL: see errors above" sim.log

clean:
	rm -rf obj_dir sim.log
